//--- Makefile
# Verilator build and run of the board testbench
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- common/board_pkg.sv
package board_pkg;

    // Board address map, one region per peripheral

    // Boot ROM, 4 KB at the bottom of the map
    localparam logic [63:0] rom_base = 64'h0000_0000_0000_0000;

    // Program RAM, directly above the ROM
    localparam logic [63:0] ram_base = 64'h0000_0000_0000_1000;

    // Console output register, write only
    localparam logic [63:0] console_base = 64'h0000_0000_8000_0000;

    // Keyboard data register, read only
    localparam logic [63:0] key_base = 64'h0000_0000_8000_0010;

    // Default memory depths in 32-bit words
    localparam int rom_words_dflt = 1024;
    localparam int ram_words_dflt = 2048;

    // Returned for reads that hit no region
    localparam logic [63:0] unmapped_fill = 64'hDEAD_BEEF_DEAD_BEEF;

    // Interrupt vector codes seen by the CPU
    localparam logic [3:0] irq_none = 4'd0;
    localparam logic [3:0] irq_key = 4'd1;

    // PS/2 set 2 break prefix
    localparam logic [7:0] ps2_break = 8'hF0;

endpackage

//--- common/bus_pkg.sv
package bus_pkg;

    // CPU to memory request
    // Read and write enables are single-cycle levels
    typedef struct packed {
        logic [63:0] address;
        logic [63:0] write_data;
        logic        read_enable;
        logic        write_enable;
    } bus_req_t;

    // Memory to CPU, valid the cycle after the read
    typedef struct packed {
        logic [63:0] read_data;
    } bus_rsp_t;

    // Decoded keyboard byte with one-cycle pulses
    typedef struct packed {
        logic [7:0] code;
        logic       make;
        logic       brk;
    } key_event_t;

    // One console character per strobe
    typedef struct packed {
        logic       strobe;
        logic [7:0] char;
    } tx_beat_t;

endpackage

//--- ps2/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  PS2_CLK,
    input  logic                  PS2_DAT,
    output bus_pkg::key_event_t   key_event
);
    import board_pkg::*;

    // Two-flop synchronizers, bit 1 is the safe copy
    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        clk_fall;
    // Frame assembly, LSB first
    logic [10:0] frame_sr;
    logic [3:0]  bit_cnt;
    logic [10:0] frame;
    logic        frame_ok;
    logic        frame_done;
    // Decoder state
    logic        brk_seen;
    logic [7:0]  code_q;
    logic        make_q;
    logic        brk_q;

    // Idle lines are high, so reset to 1 to avoid a false edge
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], PS2_CLK};
            dat_sync <= {dat_sync[0], PS2_DAT};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev && !clk_sync[1];

    // Full frame as seen while the stop bit is sampled
    // [0] start, [8:1] data, [9] parity, [10] stop
    assign frame = {dat_sync[1], frame_sr[10:1]};
    // Odd parity over data plus parity bit
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);
    assign frame_done = clk_fall && (bit_cnt == 4'd10);

    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame_sr <= {dat_sync[1], frame_sr[10:1]};
        end
        if (frame_done && frame_ok) begin
            code_q <= frame[8:1];
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt  <= '0;
            brk_seen <= 1'b0;
            make_q   <= 1'b0;
            brk_q    <= 1'b0;
        end else begin
            // Pulses last one cycle
            make_q <= 1'b0;
            brk_q  <= 1'b0;
            if (frame_done) begin
                bit_cnt <= '0;
                if (frame_ok) begin
                    if (frame[8:1] == ps2_break) begin
                        brk_seen <= 1'b1;
                    end else if (brk_seen) begin
                        brk_q    <= 1'b1;
                        brk_seen <= 1'b0;
                    end else begin
                        make_q <= 1'b1;
                    end
                end
            end else if (clk_fall && (bit_cnt != 4'd0 || !dat_sync[1])) begin
                // Wait at zero until a real start bit
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    assign key_event.code = code_q;
    assign key_event.make = make_q;
    assign key_event.brk  = brk_q;

    // A byte is either a make or a break, never both
    a_make_brk_excl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(key_event.make && key_event.brk));

endmodule

//--- rom.hex
// Boot ROM image: one 32-bit word per line in hex, word 0 first
00001137
00010113
000012b7
00028293
80000337
01030313
00032383
fe038ee3
00730023
ff5ff06f
deadc0de
0badf00d
13579bdf
2468ace0
a5a55a5a
0f1e2d3c

//--- tb.f
common/board_pkg.sv
common/bus_pkg.sv
ps2/ps2_receiver.sv
verilog/key_irq.sv
verilog/mem_bus.sv
verilog/console_port.sv
verilog/soc_board.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- verif/tb_checker.sv
`timescale 1ns/100ps

module tb_checker (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  logic                PS2_CLK,
    input  logic                PS2_DAT,
    input  bus_pkg::bus_req_t   bus_req,
    input  logic                irq_ack,
    input  bus_pkg::bus_rsp_t   bus_rsp,
    input  logic [3:0]          irq_vector,
    input  bus_pkg::tx_beat_t   tx,
    input  logic [7:0]          LEDG,
    input  logic                LEDR7,
    output int                  err_count
);
    import board_pkg::*;

    // Cycles allowed from the model's stop bit to a raised vector
    localparam int raise_limit = 12;

    // ROM model covers only the 16 words of the image
    logic [31:0] rom_model [16];
    logic [31:0] ram_model [16];
    logic [63:0] wr_off;
    // Pending read result
    logic        rd_pend;
    logic [63:0] rd_exp;
    // Console model
    logic        con_pend;
    logic [7:0]  con_char;
    logic [7:0]  led_model;
    // Key and interrupt model
    logic [7:0]  key_model;
    logic        irq_pend;
    int          raise_wait;
    logic [3:0]  vec_q;
    // PS/2 line decoder
    logic        ps2_clk_q;
    logic [9:0]  bits;
    logic [3:0]  nbits;
    logic        brk_next;
    logic [7:0]  fr_data;
    logic        fr_ok;

    initial $readmemh("rom.hex", rom_model);

    assign wr_off = bus_req.address - ram_base;

    // Frame as seen at the stop bit
    assign fr_data = bits[8:1];
    assign fr_ok = !bits[0] && PS2_DAT && (bits[9] == ~^bits[8:1]);

    // Read value from the address map
    function automatic logic [63:0] expected_read(input logic [63:0] addr);
        logic [63:0] rom_off;
        logic [63:0] ram_off;
        rom_off = addr - rom_base;
        ram_off = addr - ram_base;
        if (addr == key_base) begin
            return {56'd0, key_model};
        end else if (rom_off < 64'd64) begin
            return {32'd0, rom_model[rom_off[5:2]]};
        end else if (ram_off < 64'd64) begin
            return {32'd0, ram_model[ram_off[5:2]]};
        end
        return unmapped_fill;
    endfunction

    task automatic value_error(input string sig, input logic [63:0] exp_v,
                               input logic [63:0] got);
        $display("CHECK FAILED %s expected 0x%0h got 0x%0h at %0t", sig, exp_v, got, $time);
        err_count++;
    endtask

    task automatic plain_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        err_count++;
    endtask

    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_pend    <= 1'b0;
            con_pend   <= 1'b0;
            led_model  <= '0;
            key_model  <= '0;
            irq_pend   <= 1'b0;
            raise_wait <= 0;
            vec_q      <= irq_none;
            ps2_clk_q  <= 1'b1;
            nbits      <= '0;
            brk_next   <= 1'b0;
        end else begin
            // Read data lands one cycle after the read
            if (rd_pend && bus_rsp.read_data !== rd_exp) begin
                value_error("bus_rsp.read_data", rd_exp, bus_rsp.read_data);
            end
            rd_pend <= bus_req.read_enable;
            rd_exp  <= expected_read(bus_req.address);
            // Only the modeled RAM window takes writes
            if (bus_req.write_enable && wr_off < 64'd64) begin
                ram_model[wr_off[5:2]] <= bus_req.write_data[31:0];
            end

            // Console strobe one cycle after each write
            if (tx.strobe !== con_pend) begin
                value_error("tx.strobe", {63'd0, con_pend}, {63'd0, tx.strobe});
            end else if (con_pend && tx.char !== con_char) begin
                value_error("tx.char", {56'd0, con_char}, {56'd0, tx.char});
            end
            if (LEDG !== led_model) begin
                value_error("LEDG", {56'd0, led_model}, {56'd0, LEDG});
            end
            con_pend <= bus_req.write_enable && bus_req.address == console_base;
            if (bus_req.write_enable && bus_req.address == console_base) begin
                con_char  <= bus_req.write_data[7:0];
                led_model <= bus_req.write_data[7:0];
            end

            // Vector only while a key is pending
            if (irq_vector != irq_none && (!irq_pend || irq_vector != irq_key)) begin
                value_error("irq_vector", {60'd0, irq_pend ? irq_key : irq_none},
                            {60'd0, irq_vector});
            end
            // Lamp follows the vector one cycle late
            vec_q <= irq_vector;
            if (LEDR7 !== (vec_q != irq_none)) begin
                value_error("LEDR7", {63'd0, vec_q != irq_none}, {63'd0, LEDR7});
            end
            if (irq_vector != irq_none) begin
                raise_wait <= 0;
            end else if (raise_wait > 0) begin
                if (raise_wait == raise_limit) begin
                    plain_error("interrupt was not raised after a valid key frame");
                end
                raise_wait <= raise_wait + 1;
            end else if (irq_pend) begin
                // A raised vector holds until acknowledged
                plain_error("interrupt vector dropped before it was acknowledged");
            end
            if (irq_ack && irq_vector != irq_none) begin
                irq_pend <= 1'b0;
            end

            // Bits count from the first low start bit on a falling PS/2 clock
            ps2_clk_q <= PS2_CLK;
            if (ps2_clk_q && !PS2_CLK) begin
                if (nbits == 4'd10) begin
                    nbits <= '0;
                    if (fr_ok) begin
                        if (fr_data == ps2_break) begin
                            brk_next <= 1'b1;
                        end else if (brk_next) begin
                            brk_next <= 1'b0;
                        end else if (fr_data != 8'd0) begin
                            key_model  <= fr_data;
                            irq_pend   <= 1'b1;
                            raise_wait <= 1;
                        end
                    end
                end else if (nbits != 4'd0 || !PS2_DAT) begin
                    bits[nbits] <= PS2_DAT;
                    nbits       <= nbits + 4'd1;
                end
            end
        end
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/100ps

module tb_top;
    import board_pkg::*;
    import bus_pkg::*;

    // System cycles per PS/2 half period
    localparam int half_cycles = 10;
    // Frame plus settle time
    localparam int frame_cycles = 23 * half_cycles + 24;
    localparam int n_frames = 7;
    localparam int n_bus_ops = 160;
    // Up to 4 cycles per bus op, doubled, plus margin
    localparam int cycle_limit = 2 * (n_bus_ops * 4 + n_frames * frame_cycles) + 500;

    logic        CLOCK_50;
    logic        KEY0;
    logic        PS2_CLK;
    logic        PS2_DAT;
    bus_req_t    bus_req;
    logic        irq_ack;
    bus_rsp_t    bus_rsp;
    logic [3:0]  irq_vector;
    tx_beat_t    tx;
    logic [7:0]  LEDG;
    logic        LEDR7;
    int          err_count;
    int          prev_err;
    int          failed_tests;
    int          cycle_cnt;
    logic [31:0] rng;
    logic [7:0]  code;

    soc_board DUT (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .bus_req   (bus_req),
        .irq_ack   (irq_ack),
        .bus_rsp   (bus_rsp),
        .irq_vector(irq_vector),
        .tx        (tx),
        .LEDG      (LEDG),
        .LEDR7     (LEDR7)
    );

    tb_checker u_check (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .PS2_CLK   (PS2_CLK),
        .PS2_DAT   (PS2_DAT),
        .bus_req   (bus_req),
        .irq_ack   (irq_ack),
        .bus_rsp   (bus_rsp),
        .irq_vector(irq_vector),
        .tx        (tx),
        .LEDG      (LEDG),
        .LEDR7     (LEDR7),
        .err_count (err_count)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Single-cycle read, then one idle cycle
    task automatic bus_read(input logic [63:0] addr);
        @(posedge CLOCK_50);
        bus_req.address      <= addr;
        bus_req.read_enable  <= 1'b1;
        bus_req.write_enable <= 1'b0;
        @(posedge CLOCK_50);
        bus_req.read_enable  <= 1'b0;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
        @(posedge CLOCK_50);
        bus_req.address      <= addr;
        bus_req.write_data   <= data;
        bus_req.read_enable  <= 1'b0;
        bus_req.write_enable <= 1'b1;
        @(posedge CLOCK_50);
        bus_req.write_enable <= 1'b0;
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            PS2_DAT <= bits[0];
            bits = bits >> 1;
            repeat (half_cycles) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (half_cycles) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
        end
        @(posedge CLOCK_50);
        PS2_DAT <= 1'b1;
    endtask

    // Bounded wait for the vector, sampled mid-cycle
    task automatic wait_irq();
        int waited;
        waited = 0;
        @(negedge CLOCK_50);
        while (irq_vector == irq_none && waited < 40) begin
            @(negedge CLOCK_50);
            waited++;
        end
    endtask

    task automatic pulse_ack();
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
    endtask

    // Nonzero code that is not the break prefix
    task automatic pick_code();
        rng = xorshift32(rng);
        code = rng[7:0];
        if (code == 8'd0 || code == ps2_break) begin
            code = 8'h1C;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        repeat (4) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        errs = err_count - prev_err;
        prev_err = err_count;
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, errs);
            failed_tests++;
        end
    endtask

    // Run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge CLOCK_50);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        KEY0         = 1'b0;
        PS2_CLK      = 1'b1;
        PS2_DAT      = 1'b1;
        irq_ack      = 1'b0;
        bus_req      = '0;
        rng          = 32'd59;
        prev_err     = 0;
        failed_tests = 0;
        repeat (3) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // ROM reads and an ignored ROM write
        for (int i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            bus_read(rom_base + {58'd0, rng[3:0], 2'b00});
        end
        rng = xorshift32(rng);
        bus_write(rom_base + 64'd8, {rng, rng});
        bus_read(rom_base + 64'd8);
        finish_test(1, "ROM reads");

        // Preload the RAM window, then mixed traffic
        for (int i = 0; i < 16; i++) begin
            rng = xorshift32(rng);
            bus_write(ram_base + {58'd0, 4'(i), 2'b00}, {rng, ~rng});
        end
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            if (rng[20]) begin
                bus_write(ram_base + {58'd0, rng[3:0], 2'b00}, {rng, rng ^ 32'h5A5A_5A5A});
            end else begin
                bus_read(ram_base + {58'd0, rng[3:0], 2'b00});
            end
        end
        finish_test(2, "RAM traffic");

        // Top address bit set is always unmapped
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            bus_read({1'b1, rng[30:0], rng});
        end
        bus_read(key_base);
        finish_test(3, "Unmapped and idle key reads");

        // Console writes with random gaps
        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            bus_write(console_base, {~rng, rng});
            repeat (int'(rng[9:8])) @(posedge CLOCK_50);
        end
        finish_test(4, "Console writes");

        for (int i = 0; i < 3; i++) begin
            pick_code();
            send_frame(code, 1'b0);
            wait_irq();
            repeat (2) @(posedge CLOCK_50);
            bus_read(key_base);
            pulse_ack();
        end
        finish_test(5, "Key interrupt");

        // Break sequence
        pick_code();
        send_frame(ps2_break, 1'b0);
        send_frame(code, 1'b0);
        repeat (24) @(posedge CLOCK_50);
        bus_read(key_base);
        // Bad parity
        pick_code();
        send_frame(code, 1'b1);
        repeat (24) @(posedge CLOCK_50);
        bus_read(key_base);
        // Zero make code
        send_frame(8'h00, 1'b0);
        repeat (24) @(posedge CLOCK_50);
        bus_read(key_base);
        finish_test(6, "Rejected frames");

        $display("Summary: 6 tests, %0d failed, %0d check errors", failed_tests, err_count);
        if (failed_tests == 0 && err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/console_port.sv
`timescale 1ns/100ps

module console_port (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  bus_pkg::tx_beat_t   console_wr,
    input  logic [3:0]          irq_vector,
    output bus_pkg::tx_beat_t   tx,
    output logic [7:0]          LEDG,
    output logic                LEDR7
);
    import board_pkg::*;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            tx    <= '0;
            LEDG  <= '0;
            LEDR7 <= 1'b0;
        end else begin
            // One strobe per write, one cycle late
            tx.strobe <= console_wr.strobe;
            if (console_wr.strobe) begin
                tx.char <= console_wr.char;
                LEDG    <= console_wr.char;
            end
            // Pending interrupt lamp
            LEDR7 <= irq_vector != irq_none;
        end
    end

    a_one_strobe: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (tx.strobe && !console_wr.strobe) |=> !tx.strobe);

endmodule

//--- verilog/key_irq.sv
`timescale 1ns/100ps

module key_irq (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  bus_pkg::key_event_t   key_event,
    input  logic                  irq_ack,
    output logic [7:0]            key_code,
    output logic [3:0]            irq_vector
);
    import board_pkg::*;

    logic new_key;

    // Only nonzero make codes raise the interrupt
    assign new_key = key_event.make && (key_event.code != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code   <= '0;
            irq_vector <= irq_none;
        end else begin
            if (new_key) begin
                // A fresh key wins over an ack in the same cycle
                key_code   <= key_event.code;
                irq_vector <= irq_key;
            end else if (irq_vector != irq_none && irq_ack) begin
                irq_vector <= irq_none;
            end
        end
    end

    // Only two vector codes exist on this board
    a_vec_legal: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_vector == irq_none || irq_vector == irq_key);

endmodule

//--- verilog/mem_bus.sv
`timescale 1ns/100ps

module mem_bus #(
    parameter int ROM_WORDS = board_pkg::rom_words_dflt,
    parameter int RAM_WORDS = board_pkg::ram_words_dflt
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    input  bus_pkg::bus_req_t   bus_req,
    input  logic [7:0]          key_code,
    output bus_pkg::bus_rsp_t   bus_rsp,
    output bus_pkg::tx_beat_t   console_wr
);
    import board_pkg::*;

    localparam int rom_aw = $clog2(ROM_WORDS);
    localparam int ram_aw = $clog2(RAM_WORDS);
    localparam logic [63:0] rom_bytes = 64'(ROM_WORDS) * 64'd4;
    localparam logic [63:0] ram_bytes = 64'(RAM_WORDS) * 64'd4;

    // 32-bit word memories
    logic [31:0]       rom [ROM_WORDS];
    logic [31:0]       ram [RAM_WORDS];
    // Offsets into each region
    logic [63:0]       rom_off;
    logic [63:0]       ram_off;
    logic              rom_sel;
    logic              ram_sel;
    logic              key_sel;
    logic              con_sel;
    logic [rom_aw-1:0] rom_idx;
    logic [ram_aw-1:0] ram_idx;
    logic [63:0]       rd_next;
    logic [63:0]       rd_q;

    // Boot image
    initial $readmemh("rom.hex", rom);

    // Region decode, subtract then compare against size
    assign rom_off = bus_req.address - rom_base;
    assign ram_off = bus_req.address - ram_base;
    assign rom_sel = rom_off < rom_bytes;
    assign ram_sel = ram_off < ram_bytes;
    assign key_sel = bus_req.address == key_base;
    assign con_sel = bus_req.address == console_base;

    // Word index from address bits above bit 1
    assign rom_idx = rom_off[rom_aw+1:2];
    assign ram_idx = ram_off[ram_aw+1:2];

    // Read mux, upper bits zero
    always_comb begin
        if (key_sel) begin
            rd_next = {56'd0, key_code};
        end else if (rom_sel) begin
            rd_next = {32'd0, rom[rom_idx]};
        end else if (ram_sel) begin
            rd_next = {32'd0, ram[ram_idx]};
        end else begin
            rd_next = unmapped_fill;
        end
    end

    // Read data held until the next read
    always_ff @(posedge CLOCK_50) begin
        if (bus_req.read_enable) begin
            rd_q <= rd_next;
        end
        // Only RAM takes writes, ROM writes fall away
        if (bus_req.write_enable && ram_sel) begin
            ram[ram_idx] <= bus_req.write_data[31:0];
        end
    end

    assign bus_rsp.read_data = rd_q;

    // Console write flag, registered downstream
    assign console_wr.strobe = bus_req.write_enable && con_sel;
    assign console_wr.char   = bus_req.write_data[7:0];

    // CPU side never reads and writes at once
    a_rw_excl: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_req.read_enable && bus_req.write_enable));

endmodule

//--- verilog/soc_board.sv
`timescale 1ns/100ps

module soc_board #(
    parameter int ROM_WORDS = board_pkg::rom_words_dflt,
    parameter int RAM_WORDS = board_pkg::ram_words_dflt
) (
    // Board clock and reset button
    input  logic                CLOCK_50,
    input  logic                KEY0,
    // Keyboard connector
    input  logic                PS2_CLK,
    input  logic                PS2_DAT,
    // CPU side of the bus
    input  bus_pkg::bus_req_t   bus_req,
    input  logic                irq_ack,
    output bus_pkg::bus_rsp_t   bus_rsp,
    output logic [3:0]          irq_vector,
    // Console and lamps
    output bus_pkg::tx_beat_t   tx,
    output logic [7:0]          LEDG,
    output logic                LEDR7
);
    import bus_pkg::*;

    key_event_t key_ev;
    logic [7:0] key_code;
    tx_beat_t   console_wr;

    // Input side
    ps2_receiver u_ps2 (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .key_event(key_ev)
    );

    key_irq u_irq (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_event (key_ev),
        .irq_ack   (irq_ack),
        .key_code  (key_code),
        .irq_vector(irq_vector)
    );

    // Memory map
    mem_bus #(
        .ROM_WORDS(ROM_WORDS),
        .RAM_WORDS(RAM_WORDS)
    ) u_bus (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_req   (bus_req),
        .key_code  (key_code),
        .bus_rsp   (bus_rsp),
        .console_wr(console_wr)
    );

    // Output side
    console_port u_con (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .console_wr(console_wr),
        .irq_vector(irq_vector),
        .tx        (tx),
        .LEDG      (LEDG),
        .LEDR7     (LEDR7)
    );

endmodule
